/* design/csense_pkg.sv */
// Shared widths, bus structs, FSM encoding and register map; one dsp_clk domain, no CDC anywhere

package csense_pkg;

   ////////////////////////////////////////
   // Widths and plain types

   localparam int WORD_W = 32;
   localparam int IQ_W   = 16;
   localparam int RSSI_W = 17;   // |I|+|Q| at full scale needs one bit more than IQ_W
   localparam int SLOT_W = 16;
   localparam int LED_W  = 8;
   localparam int APB_AW = 5;    // 8 words, byte addressed

   typedef logic        [WORD_W-1:0] cs_word_t;
   typedef logic signed [IQ_W-1:0]   iq_t;
   typedef logic        [RSSI_W-1:0] rssi_t;
   typedef logic        [SLOT_W-1:0] slot_t;
   typedef logic        [LED_W-1:0]  led_t;
   typedef logic        [2:0]        reg_idx_t;   // paddr[4:2]

   ////////////////////////////////////////
   // Bundles

   typedef struct packed {
      logic              psel;
      logic              penable;
      logic              pwrite;
      logic [APB_AW-1:0] paddr;
      cs_word_t          pwdata;
   } apb_req_t;

   typedef struct packed {
      cs_word_t prdata;
      logic     pready;
      logic     pslverr;
   } apb_rsp_t;

   typedef struct packed {
      logic strobe;      // Sample valid, no back-pressure
      iq_t  i;
      iq_t  q;
   } rx_sample_t;

   typedef struct packed {
      logic  enable;     // Carrier sense on
      rssi_t threshold;
      slot_t slot_len;   // In dsp_clk cycles
   } cs_cfg_t;

   typedef enum logic [1:0] {
      CS_IDLE   = 2'd0,
      CS_LISTEN = 2'd1,
      CS_GRANT  = 2'd2
   } cs_state_e;

   ////////////////////////////////////////
   // Register map and reset values

   localparam reg_idx_t REG_CS_SET   = 3'd0;
   localparam reg_idx_t REG_CS_THR   = 3'd1;
   localparam reg_idx_t REG_CS_SLT   = 3'd2;
   localparam reg_idx_t REG_LED_SW   = 3'd3;
   localparam reg_idx_t REG_LED_SRC  = 3'd4;
   localparam reg_idx_t REG_AVG_RSSI = 3'd5;   // Read only from here up
   localparam reg_idx_t REG_STATUS   = 3'd6;
   localparam reg_idx_t REG_COMPAT   = 3'd7;

   localparam cs_word_t COMPAT_NUM    = {16'd11, 16'd1};   // Major, minor
   localparam led_t     LED_SRC_RESET = 8'h1E;
   localparam slot_t    SLOT_RESET    = 16'd16;
   localparam rssi_t    THR_RESET     = 17'd1000;

endpackage

/* design/cs_regs.sv */
// APB slave with one wait state per transfer; writes to indices 5 to 7 are dropped and return pslverr
`timescale 1ns/1ps

module cs_regs (
   input  logic                  dsp_clk,
   input  logic                  por_rst,
   input  csense_pkg::apb_req_t  apb_i,
   output csense_pkg::apb_rsp_t  apb_o,
   input  csense_pkg::rssi_t     avg_rssi_i,
   input  logic                  busy_i,
   input  logic                  send_i,
   input  csense_pkg::cs_state_e state_i,
   input  csense_pkg::slot_t     defer_cnt_i,
   output csense_pkg::cs_cfg_t   cfg_o,
   output csense_pkg::led_t      leds_o
);

   csense_pkg::reg_idx_t idx;
   logic                 acc_first;   // First access cycle, pready still low
   logic                 acc_last;    // Access cycle that carries pready
   logic                 ro_idx;
   logic                 pready_q;
   logic                 pslverr_q;
   csense_pkg::cs_word_t prdata_q;
   csense_pkg::cs_word_t rd_mux;
   csense_pkg::cs_cfg_t  cfg_q;
   csense_pkg::led_t     led_sw_q;
   csense_pkg::led_t     led_src_q;
   csense_pkg::led_t     led_hw;

   assign idx       = apb_i.paddr[4:2];
   assign acc_first = apb_i.psel & apb_i.penable & ~pready_q;
   assign acc_last  = apb_i.psel & apb_i.penable & pready_q;
   assign ro_idx    = (idx == csense_pkg::REG_AVG_RSSI) | (idx == csense_pkg::REG_STATUS) |
                      (idx == csense_pkg::REG_COMPAT);

   ////////////////////////////////////////
   // Handshake

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         pready_q  <= 1'b0;
         pslverr_q <= 1'b0;
      end else begin
         pready_q  <= acc_first;                          // High for exactly one cycle
         pslverr_q <= acc_first & apb_i.pwrite & ro_idx;
      end
   end

   always_ff @(posedge dsp_clk) begin
      if (acc_first) begin
         prdata_q <= rd_mux;   // Sampled one cycle ahead of pready
      end
   end

   always_comb begin
      case (idx)
         csense_pkg::REG_CS_SET:   rd_mux = csense_pkg::cs_word_t'(cfg_q.enable);
         csense_pkg::REG_CS_THR:   rd_mux = csense_pkg::cs_word_t'(cfg_q.threshold);
         csense_pkg::REG_CS_SLT:   rd_mux = csense_pkg::cs_word_t'(cfg_q.slot_len);
         csense_pkg::REG_LED_SW:   rd_mux = csense_pkg::cs_word_t'(led_sw_q);
         csense_pkg::REG_LED_SRC:  rd_mux = csense_pkg::cs_word_t'(led_src_q);
         csense_pkg::REG_AVG_RSSI: rd_mux = csense_pkg::cs_word_t'(avg_rssi_i);
         csense_pkg::REG_STATUS:   rd_mux = {defer_cnt_i, 14'd0, 2'(state_i)};
         csense_pkg::REG_COMPAT:   rd_mux = csense_pkg::COMPAT_NUM;
         default:                  rd_mux = '0;
      endcase
   end

   assign apb_o.prdata  = prdata_q;
   assign apb_o.pready  = pready_q;
   assign apb_o.pslverr = pslverr_q;

   ////////////////////////////////////////
   // Config and LED registers

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         cfg_q.enable    <= 1'b0;
         cfg_q.threshold <= csense_pkg::THR_RESET;
         cfg_q.slot_len  <= csense_pkg::SLOT_RESET;
         led_sw_q        <= '0;
         led_src_q       <= csense_pkg::LED_SRC_RESET;
      end else if (acc_last && apb_i.pwrite && !ro_idx) begin
         case (idx)
            csense_pkg::REG_CS_SET:  cfg_q.enable    <= apb_i.pwdata[0];
            csense_pkg::REG_CS_THR:  cfg_q.threshold <= apb_i.pwdata[csense_pkg::RSSI_W-1:0];
            csense_pkg::REG_CS_SLT:  cfg_q.slot_len  <= apb_i.pwdata[csense_pkg::SLOT_W-1:0];
            csense_pkg::REG_LED_SW:  led_sw_q        <= apb_i.pwdata[csense_pkg::LED_W-1:0];
            csense_pkg::REG_LED_SRC: led_src_q       <= apb_i.pwdata[csense_pkg::LED_W-1:0];
            default: ;
         endcase
      end
   end

   assign cfg_o = cfg_q;

   // Source bit 1 picks the hardware bit, 0 the software bit
   assign led_hw = {4'b0000, state_i != csense_pkg::CS_IDLE, cfg_q.enable, send_i, busy_i};
   assign leds_o = (led_src_q & led_hw) | (~led_src_q & led_sw_q);

endmodule

/* design/rssi_avg.sv */
// Averages |I|+|Q| over blocks of 2**AVG_LOG2 strobed samples; AVG_LOG2 from 1 to 8 only
`timescale 1ns/1ps

module rssi_avg #(
   parameter int AVG_LOG2 = 4
) (
   input  logic                   dsp_clk,
   input  logic                   por_rst,
   input  csense_pkg::rx_sample_t rx_i,
   input  csense_pkg::rssi_t      threshold_i,
   output csense_pkg::rssi_t      avg_rssi_o,
   output logic                   busy_o
);

   localparam int ACC_W = csense_pkg::RSSI_W + AVG_LOG2;   // Block sum never overflows

   logic signed [csense_pkg::RSSI_W-1:0] i_ext;
   logic signed [csense_pkg::RSSI_W-1:0] q_ext;
   csense_pkg::rssi_t                    i_mag;
   csense_pkg::rssi_t                    q_mag;
   csense_pkg::rssi_t                    mag;
   logic [ACC_W-1:0]                     acc_q;
   logic [ACC_W-1:0]                     acc_sum;
   logic [AVG_LOG2-1:0]                  cnt_q;   // Samples so far in this block
   csense_pkg::rssi_t                    avg_next;
   csense_pkg::rssi_t                    avg_q;
   logic                                 busy_q;

   ////////////////////////////////////////
   // Sample magnitude

   // Extra sign bit lets -32768 negate without wrapping
   assign i_ext = {rx_i.i[csense_pkg::IQ_W-1], rx_i.i};
   assign q_ext = {rx_i.q[csense_pkg::IQ_W-1], rx_i.q};
   assign i_mag = i_ext[csense_pkg::RSSI_W-1] ? -i_ext : i_ext;
   assign q_mag = q_ext[csense_pkg::RSSI_W-1] ? -q_ext : q_ext;
   assign mag   = i_mag + q_mag;

   ////////////////////////////////////////
   // Block accumulate

   assign acc_sum  = acc_q + ACC_W'(mag);
   assign avg_next = csense_pkg::rssi_t'(acc_sum >> AVG_LOG2);

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         acc_q  <= '0;
         cnt_q  <= '0;
         avg_q  <= '0;
         busy_q <= 1'b0;
      end else if (rx_i.strobe) begin
         cnt_q <= cnt_q + 1'b1;   // Wraps at block end
         if (&cnt_q) begin
            acc_q  <= '0;
            avg_q  <= avg_next;
            busy_q <= avg_next > threshold_i;   // Compared with the new average
         end else begin
            acc_q <= acc_sum;
         end
      end
   end

   assign avg_rssi_o = avg_q;
   assign busy_o     = busy_q;

endmodule

/* design/slot_timer.sv */
// One-shot slot timer; expired fires slot_len cycles after restart and a length of 0 counts as 1
`timescale 1ns/1ps

module slot_timer (
   input  logic              dsp_clk,
   input  logic              por_rst,
   input  logic              restart_i,
   input  csense_pkg::slot_t slot_len_i,
   output logic              expired_o
);

   csense_pkg::slot_t cnt_q;
   csense_pkg::slot_t load_val;
   logic              running_q;

   assign load_val  = (slot_len_i == '0) ? csense_pkg::slot_t'(1) : slot_len_i;
   assign expired_o = running_q & (cnt_q == csense_pkg::slot_t'(1));

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         cnt_q     <= '0;
         running_q <= 1'b0;
      end else if (restart_i) begin
         cnt_q     <= load_val;   // Restart wins over a running count
         running_q <= 1'b1;
      end else if (running_q) begin
         cnt_q <= cnt_q - 1'b1;
         if (expired_o) begin
            running_q <= 1'b0;   // Idle until next restart
         end
      end
   end

endmodule

/* design/cs_fsm.sv */
// Listen-before-talk control; tx_req_i must hold until send_o and a busy slot just listens again
`timescale 1ns/1ps

module cs_fsm (
   input  logic                  dsp_clk,
   input  logic                  por_rst,
   input  logic                  enable_i,
   input  logic                  tx_req_i,
   input  logic                  eof_i,
   input  logic                  busy_i,
   input  logic                  expired_i,
   output logic                  restart_o,
   output logic                  send_o,
   output csense_pkg::cs_state_e state_o,
   output csense_pkg::slot_t     defer_cnt_o
);

   csense_pkg::cs_state_e state_q;
   csense_pkg::slot_t     defer_q;   // Busy slots seen for this request
   logic                  restart_q;

   ////////////////////////////////////////
   // State machine

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         state_q   <= csense_pkg::CS_IDLE;
         defer_q   <= '0;
         restart_q <= 1'b0;
      end else begin
         restart_q <= 1'b0;   // Single-cycle pulse
         case (state_q)
            csense_pkg::CS_IDLE: begin
               if (tx_req_i) begin
                  defer_q <= '0;
                  if (enable_i) begin
                     state_q   <= csense_pkg::CS_LISTEN;
                     restart_q <= 1'b1;   // First slot
                  end else begin
                     state_q <= csense_pkg::CS_GRANT;   // No carrier sense
                  end
               end
            end
            csense_pkg::CS_LISTEN: begin
               if (!enable_i) begin
                  state_q <= csense_pkg::CS_GRANT;   // Disabled while waiting
               end else if (expired_i) begin
                  if (busy_i) begin
                     restart_q <= 1'b1;
                     if (defer_q != '1) begin
                        defer_q <= defer_q + 1'b1;
                     end
                  end else begin
                     state_q <= csense_pkg::CS_GRANT;   // Whole slot was quiet
                  end
               end
            end
            csense_pkg::CS_GRANT: begin
               if (eof_i) begin
                  state_q <= csense_pkg::CS_IDLE;
               end
            end
            default: state_q <= csense_pkg::CS_IDLE;
         endcase
      end
   end

   assign restart_o   = restart_q;
   assign send_o      = (state_q == csense_pkg::CS_GRANT);   // Drops the cycle after eof_i
   assign state_o     = state_q;
   assign defer_cnt_o = defer_q;

endmodule

/* design/csense_top.sv */
// Carrier-sense core top; everything runs on dsp_clk and por_rst is synchronous
`timescale 1ns/1ps

module csense_top #(
   parameter int AVG_LOG2 = 4   // Block of 16 samples
) (
   input  logic                   dsp_clk,
   input  logic                   por_rst,
   input  csense_pkg::apb_req_t   apb_i,
   output csense_pkg::apb_rsp_t   apb_o,
   input  csense_pkg::rx_sample_t rx_i,
   input  logic                   tx_req_i,
   input  logic                   eof_i,
   output logic                   send_o,
   output csense_pkg::led_t       leds_o
);

   csense_pkg::cs_cfg_t   cfg;
   csense_pkg::rssi_t     avg_rssi;
   logic                  busy;
   logic                  restart;
   logic                  expired;
   csense_pkg::cs_state_e state;
   csense_pkg::slot_t     defer_cnt;

   ////////////////////////////////////////
   // Register bank

   cs_regs u_regs (
      .dsp_clk     (dsp_clk),
      .por_rst     (por_rst),
      .apb_i       (apb_i),
      .apb_o       (apb_o),
      .avg_rssi_i  (avg_rssi),
      .busy_i      (busy),
      .send_i      (send_o),
      .state_i     (state),
      .defer_cnt_i (defer_cnt),
      .cfg_o       (cfg),
      .leds_o      (leds_o)
   );

   ////////////////////////////////////////
   // Sense path

   rssi_avg #(.AVG_LOG2(AVG_LOG2)) u_avg (
      .dsp_clk     (dsp_clk),
      .por_rst     (por_rst),
      .rx_i        (rx_i),
      .threshold_i (cfg.threshold),
      .avg_rssi_o  (avg_rssi),
      .busy_o      (busy)
   );

   slot_timer u_slot (
      .dsp_clk    (dsp_clk),
      .por_rst    (por_rst),
      .restart_i  (restart),
      .slot_len_i (cfg.slot_len),
      .expired_o  (expired)
   );

   cs_fsm u_fsm (
      .dsp_clk     (dsp_clk),
      .por_rst     (por_rst),
      .enable_i    (cfg.enable),
      .tx_req_i    (tx_req_i),
      .eof_i       (eof_i),
      .busy_i      (busy),
      .expired_i   (expired),
      .restart_o   (restart),
      .send_o      (send_o),
      .state_o     (state),
      .defer_cnt_o (defer_cnt)
   );

endmodule

/* bench/tb_csense.sv */
// Run from the project root so bench/csense_stim.txt is found; sample lines must fill whole blocks
`timescale 1ns/1ps

module tb_csense;

   localparam int AVG_LOG2    = 4;
   localparam int APB_TIMEOUT = 16;    // Cycles allowed for pready
   localparam int TX_TIMEOUT  = 400;   // Cycles allowed for send_o

   logic                   dsp_clk;
   logic                   por_rst;
   csense_pkg::apb_req_t   apb_req;
   csense_pkg::apb_rsp_t   apb_rsp;
   csense_pkg::rx_sample_t rx_in;
   logic                   tx_req;
   logic                   eof;
   logic                   send;
   csense_pkg::led_t       leds;

   integer            seed = 32'h12d2;
   int                model_sum = 0;   // Running |I|+|Q| of the open block
   int                model_cnt = 0;
   csense_pkg::rssi_t model_avg = '0;

   csense_top #(.AVG_LOG2(AVG_LOG2)) UUT (
      .dsp_clk  (dsp_clk),
      .por_rst  (por_rst),
      .apb_i    (apb_req),
      .apb_o    (apb_rsp),
      .rx_i     (rx_in),
      .tx_req_i (tx_req),
      .eof_i    (eof),
      .send_o   (send),
      .leds_o   (leds)
   );

   initial begin
      dsp_clk = 1'b0;
      forever #4 dsp_clk = ~dsp_clk;
   end

   ////////////////////////////////////////
   // Checks

   task automatic stop_failed();
      $display("sim failed");
      $fatal(1, "run stopped at the first error");
   endtask

   task automatic check_word(input string name, input csense_pkg::cs_word_t got,
                             input csense_pkg::cs_word_t exp);
      if (got !== exp) begin
         $display("CHECK FAILED at %0t ns: %s got %h expected %h", $time, name, got, exp);
         stop_failed();
      end
   endtask

   task automatic check_rssi(input string name, input csense_pkg::rssi_t got,
                             input csense_pkg::rssi_t exp);
      if (got !== exp) begin
         $display("CHECK FAILED at %0t ns: %s got %h expected %h", $time, name, got, exp);
         stop_failed();
      end
   endtask

   task automatic check_led(input string name, input csense_pkg::led_t got,
                            input csense_pkg::led_t exp);
      if (got !== exp) begin
         $display("CHECK FAILED at %0t ns: %s got %h expected %h", $time, name, got, exp);
         stop_failed();
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("CHECK FAILED at %0t ns: %s got %b expected %b", $time, name, got, exp);
         stop_failed();
      end
   endtask

   task automatic need_fields(input int got, input int want, input byte op);
      if (got != want) begin
         $display("ERROR: stimulus line %c has %0d fields, it needs %0d", op, got, want);
         stop_failed();
      end
   endtask

   ////////////////////////////////////////
   // Bus and sample drivers

   function automatic int iq_mag(input csense_pkg::iq_t v);
      int x;
      x = int'(v);
      return (x < 0) ? -x : x;
   endfunction

   task automatic apb_xfer(input logic wr, input csense_pkg::reg_idx_t idx,
                           input csense_pkg::cs_word_t wdata,
                           output csense_pkg::cs_word_t rdata, output logic err);
      int n;
      @(posedge dsp_clk);
      apb_req.psel    <= 1'b1;   // Setup phase
      apb_req.penable <= 1'b0;
      apb_req.pwrite  <= wr;
      apb_req.paddr   <= {idx, 2'b00};
      apb_req.pwdata  <= wdata;
      @(posedge dsp_clk);
      apb_req.penable <= 1'b1;
      n = 0;
      @(negedge dsp_clk);
      while (!apb_rsp.pready) begin
         if (n == APB_TIMEOUT) begin
            $display("ERROR at %0t ns: no pready for register index %0d", $time, idx);
            stop_failed();
         end
         n++;
         @(negedge dsp_clk);
      end
      rdata = apb_rsp.prdata;
      err   = apb_rsp.pslverr;
      @(posedge dsp_clk);
      apb_req <= '0;
   endtask

   // Strobes one sample after a random idle gap and adds it to the block model
   task automatic drive_sample(input csense_pkg::iq_t i_val, input csense_pkg::iq_t q_val);
      int gap;
      gap = int'($unsigned($random(seed)) % 32'd4);
      repeat (gap) begin
         @(posedge dsp_clk);
         rx_in.strobe <= 1'b0;
      end
      @(posedge dsp_clk);
      rx_in.strobe <= 1'b1;
      rx_in.i      <= i_val;
      rx_in.q      <= q_val;
      model_sum = model_sum + iq_mag(i_val) + iq_mag(q_val);
      model_cnt = model_cnt + 1;
      if (model_cnt == (1 << AVG_LOG2)) begin
         model_avg = csense_pkg::rssi_t'(model_sum >> AVG_LOG2);
         model_sum = 0;
         model_cnt = 0;
      end
   endtask

   ////////////////////////////////////////
   // Transmit requests

   task automatic hold_request(input int cycles);
      @(posedge dsp_clk);
      tx_req <= 1'b1;   // Left high for a later request_frame
      repeat (cycles) begin
         @(negedge dsp_clk);
         check_flag("send_o", send, 1'b0);
      end
   endtask

   task automatic request_frame(input int eof_dly);
      int n;
      @(posedge dsp_clk);
      tx_req <= 1'b1;
      n = 0;
      @(negedge dsp_clk);
      while (!send) begin
         if (n == TX_TIMEOUT) begin
            $display("ERROR at %0t ns: send_o never rose for a pending request", $time);
            stop_failed();
         end
         n++;
         @(negedge dsp_clk);
      end
      @(posedge dsp_clk);
      tx_req <= 1'b0;
      repeat (eof_dly) @(posedge dsp_clk);
      eof <= 1'b1;
      @(negedge dsp_clk);
      check_flag("send_o", send, 1'b1);   // Grant holds until eof is taken
      @(posedge dsp_clk);
      eof <= 1'b0;
      @(negedge dsp_clk);
      check_flag("send_o", send, 1'b0);
   endtask

   ////////////////////////////////////////
   // Stimulus player

   task automatic run_op(input int fd, input byte op);
      int                   code;
      int                   cnt;
      int                   k;
      logic                 flag;
      logic                 err;
      csense_pkg::reg_idx_t idx;
      csense_pkg::cs_word_t data;
      csense_pkg::cs_word_t mask;
      csense_pkg::cs_word_t rdata;
      csense_pkg::iq_t      i_val;
      csense_pkg::iq_t      q_val;
      csense_pkg::led_t     led_exp;
      logic [8*120-1:0]     skip_line;
      case (op)
         "#": code = $fgets(skip_line, fd);   // Comment line
         "W": begin
            code = $fscanf(fd, "%h %h %h", idx, data, flag);
            need_fields(code, 3, op);
            apb_xfer(1'b1, idx, data, rdata, err);
            check_flag("pslverr", err, flag);
         end
         "R": begin
            code = $fscanf(fd, "%h %h %h %h", idx, data, mask, flag);
            need_fields(code, 4, op);
            apb_xfer(1'b0, idx, '0, rdata, err);
            check_flag("pslverr", err, 1'b0);
            check_word("prdata", rdata & mask, data);
            if (flag) begin
               check_flag("defer count nonzero", |(rdata & ~mask), 1'b1);
            end
            if (idx == csense_pkg::REG_AVG_RSSI) begin
               check_rssi("avg_rssi", rdata[csense_pkg::RSSI_W-1:0], model_avg);
            end
         end
         "S": begin
            code = $fscanf(fd, "%h %h", i_val, q_val);
            need_fields(code, 2, op);
            drive_sample(i_val, q_val);
            @(posedge dsp_clk);
            rx_in.strobe <= 1'b0;
         end
         "B": begin
            code = $fscanf(fd, "%h %h %h", cnt, i_val, q_val);
            need_fields(code, 3, op);
            for (k = 0; k < cnt; k++) begin
               drive_sample(k[0] ? -i_val : i_val, q_val);   // I flips sign on odd samples
            end
            @(posedge dsp_clk);
            rx_in.strobe <= 1'b0;
         end
         "Q": begin
            code = $fscanf(fd, "%h %h", flag, cnt);
            need_fields(code, 2, op);
            if (flag) begin
               request_frame(cnt);
            end else begin
               hold_request(cnt);
            end
         end
         "L": begin
            code = $fscanf(fd, "%h", led_exp);
            need_fields(code, 1, op);
            @(negedge dsp_clk);
            check_led("leds_o", leds, led_exp);
         end
         default: begin
            $display("ERROR: unknown opcode %c in the stimulus file", op);
            stop_failed();
         end
      endcase
   endtask

   initial begin
      int  fd;
      int  code;
      byte op;
      apb_req <= '0;
      rx_in   <= '0;
      tx_req  <= 1'b0;
      eof     <= 1'b0;
      por_rst <= 1'b1;
      repeat (5) @(posedge dsp_clk);
      por_rst <= 1'b0;
      fd = $fopen("bench/csense_stim.txt", "r");
      if (fd == 0) begin
         $display("ERROR: cannot open bench/csense_stim.txt");
         stop_failed();
      end
      while (!$feof(fd)) begin
         code = $fscanf(fd, " %c", op);
         if (code == 1) begin
            run_op(fd, op);
         end
      end
      $fclose(fd);
      repeat (4) @(posedge dsp_clk);
      $display("sim passed");
      $finish;
   end

endmodule

/* bench/csense_stim.txt */
# W idx data err | R idx expect mask nz | S i q | B count i q, I negated on odd samples
# Q mode cycles, mode 0 holds the request and 1 waits for send then eof | L leds; fields in hex
# Reset values
R 0 00000000 ffffffff 0
R 1 000003e8 ffffffff 0
R 2 00000010 ffffffff 0
R 3 00000000 ffffffff 0
R 4 0000001e ffffffff 0
R 5 00000000 ffffffff 0
R 6 00000000 ffffffff 0
R 7 000b0001 ffffffff 0
L 00
# Read-only registers answer writes with pslverr
W 6 12345678 1
W 5 00000001 1
R 6 00000000 ffffffff 0
# Read/write registers and LED mux
W 1 ffffffff 0
R 1 0001ffff ffffffff 0
W 1 00000200 0
R 1 00000200 ffffffff 0
W 2 00000008 0
R 2 00000008 ffffffff 0
W 3 000000a5 0
R 3 000000a5 ffffffff 0
L a1
W 4 0000000f 0
R 4 0000000f ffffffff 0
L a0
# Full-scale block, busy shows on LED bit 0
S 8000 0000
B 7 0100 ff00
B 8 7fff 8000
R 5 000088df ffffffff 0
L a1
# Carrier sense off
Q 1 3
R 6 00000000 ffffffff 0
# Quiet block, then carrier sense on
S 0064 ff9c
S 0000 0000
B e 0040 ffc0
R 5 0000007c ffffffff 0
W 0 00000001 0
Q 1 2
R 6 00000000 ffffffff 0
# Loud channel defers the request until a quiet block
B 10 0400 0400
R 5 00000800 ffffffff 0
Q 0 28
R 6 00000001 0000ffff 1
L ad
B 10 0010 0010
R 5 00000020 ffffffff 0
Q 1 2
R 6 00000000 0000ffff 1
L a4

/* vlog.f */
design/csense_pkg.sv
design/cs_regs.sv
design/rssi_avg.sv
design/slot_timer.sv
design/cs_fsm.sv
design/csense_top.sv
bench/tb_csense.sv

/* Makefile */
SIM := obj_dir/Vtb_csense
SRC := $(shell cat vlog.f)

.PHONY: all run clean

all: run

$(SIM): vlog.f $(SRC)
	verilator --binary -j 0 --top-module tb_csense -f vlog.f

run: $(SIM)
	-./$(SIM) > sim.log 2>&1
	@cat sim.log
	@! grep -q "sim failed" sim.log
	@grep -q "sim passed" sim.log

clean:
	rm -rf obj_dir sim.log
